//--- hdl/crc8_calc.sv
`timescale 1ns/1ps
`include "frame_rx_settings.svh"

module crc8_calc (
    input  logic clk,
    input  logic reset,
    crc_if.calc  crc
);

    // CRC register and its value after one more byte
    frame_rx_pkg::crc_t crc_reg;
    frame_rx_pkg::crc_t crc_next;

    // Byte-wise update, MSB first
    // Loop unrolls into eight shift and conditional XOR stages
    always_comb begin
        crc_next = crc_reg ^ crc.data;
        for (int i = 0; i < 8; i++) begin
            // Top bit set means the polynomial divides in
            if (crc_next[7]) begin
                crc_next = (crc_next << 1) ^ `CRC8_POLY;
            end else begin
                crc_next = crc_next << 1;
            end
        end
    end

    // Register update
    // Clear beats update, otherwise hold
    always_ff @(posedge clk) begin
        if (reset || crc.clear) begin
            crc_reg <= `CRC8_INIT;
        end else if (crc.update) begin
            crc_reg <= crc_next;
        end
    end

    // Parser compares against this one cycle after the last update
    assign crc.crc = crc_reg;

endmodule

//--- hdl/frame_counter.sv
`timescale 1ns/1ps
`include "frame_rx_settings.svh"

module frame_counter (
    input  logic clk,
    input  logic reset,
    count_if.cnt cnt
);

    // Payload bytes still expected
    frame_rx_pkg::len_t remaining;

    // Idle cycles since the last load or step
    frame_rx_pkg::tmr_t idle_tmr;

    // Timeout threshold at timer width
    localparam frame_rx_pkg::tmr_t TMR_LIMIT = frame_rx_pkg::tmr_t'(`FRAME_BYTE_TIMEOUT);

    // Remaining payload count
    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= '0;
        end else if (cnt.load) begin
            remaining <= cnt.len;
        end else if (cnt.step && remaining != '0) begin
            // Never wraps below zero
            remaining <= remaining - frame_rx_pkg::len_t'(1);
        end
    end

    // Idle timer
    always_ff @(posedge clk) begin
        if (reset) begin
            idle_tmr <= '0;
        end else if (!cnt.run) begin
            // Outside a frame, hold at zero
            idle_tmr <= '0;
        end else if (cnt.load || cnt.step) begin
            // Byte activity restarts the count
            idle_tmr <= '0;
        end else if (idle_tmr != TMR_LIMIT) begin
            idle_tmr <= idle_tmr + frame_rx_pkg::tmr_t'(1);
        end
    end

    // Status straight from the registers
    assign cnt.done    = (remaining == '0);
    assign cnt.timeout = (idle_tmr == TMR_LIMIT);

endmodule

//--- hdl/frame_parser_fsm.sv
`timescale 1ns/1ps
`include "frame_rx_settings.svh"

module frame_parser_fsm (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    byte_valid,
    input  frame_rx_pkg::byte_t     byte_data,
    crc_if.fsm                      crc,
    count_if.fsm                    cnt,
    output logic                    buf_wr_en,
    output frame_rx_pkg::addr_t     buf_wr_addr,
    output logic                    frame_ok,
    output logic                    frame_err,
    output frame_rx_pkg::err_code_t err_code,
    output frame_rx_pkg::byte_t     frame_cmd,
    output frame_rx_pkg::len_t      frame_len
);

    frame_rx_pkg::parser_state_t state;

    // Fields of the frame in progress
    frame_rx_pkg::byte_t cmd_q;
    frame_rx_pkg::len_t  len_q;
    frame_rx_pkg::addr_t wr_ptr;

    // Per-byte decode of the current cycle
    logic abort;
    logic sof_byte;
    logic cmd_byte;
    logic len_byte;
    logic data_byte;
    logic crc_byte;
    logic len_bad;
    logic crc_match;
    logic pulse_now;
    frame_rx_pkg::err_code_t next_code;

    // Timeout ends any frame in progress, idle ignores it
    assign abort = cnt.timeout && (state != frame_rx_pkg::st_idle);

    // Anything other than the start byte is dropped in idle
    assign sof_byte = byte_valid && (state == frame_rx_pkg::st_idle)
                      && (byte_data == `FRAME_SOF);
    assign cmd_byte = byte_valid && !abort && (state == frame_rx_pkg::st_cmd);
    assign len_byte = byte_valid && !abort && (state == frame_rx_pkg::st_len);

    // Payload until the counter runs out
    assign data_byte = byte_valid && !abort && (state == frame_rx_pkg::st_payload)
                       && !cnt.done;

    // CRC byte may land right after the last payload byte
    assign crc_byte = byte_valid && !abort
                      && ((state == frame_rx_pkg::st_crc)
                      || ((state == frame_rx_pkg::st_payload) && cnt.done));

    assign len_bad   = (byte_data > `FRAME_MAX_PAYLOAD);
    assign crc_match = (byte_data == crc.crc);

    // Every way a frame can end in this cycle
    assign pulse_now = abort || crc_byte || (len_byte && len_bad);

    // Timeout wins, then length, then CRC check
    always_comb begin
        if (abort) begin
            next_code = frame_rx_pkg::err_timeout;
        end else if (len_byte && len_bad) begin
            next_code = frame_rx_pkg::err_len;
        end else if (crc_byte && !crc_match) begin
            next_code = frame_rx_pkg::err_crc;
        end else begin
            next_code = frame_rx_pkg::err_none;
        end
    end

    // Strobes to the CRC register
    assign crc.clear  = sof_byte;
    assign crc.update = cmd_byte || len_byte || data_byte;
    assign crc.data   = byte_data;

    // Strobes to the counter
    assign cnt.load = len_byte && !len_bad;
    assign cnt.len  = frame_rx_pkg::len_t'(byte_data);
    assign cnt.step = data_byte;
    assign cnt.run  = (state != frame_rx_pkg::st_idle);

    // Payload goes to the buffer as it arrives
    assign buf_wr_en   = data_byte;
    assign buf_wr_addr = wr_ptr;

    // State, pointer and result pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= frame_rx_pkg::st_idle;
            wr_ptr    <= '0;
            frame_ok  <= 1'b0;
            frame_err <= 1'b0;
            err_code  <= frame_rx_pkg::err_none;
        end else begin
            frame_ok  <= crc_byte && crc_match;
            frame_err <= pulse_now && (next_code != frame_rx_pkg::err_none);
            if (pulse_now) begin
                err_code <= next_code;
            end
            if (len_byte) begin
                wr_ptr <= '0;
            end else if (data_byte) begin
                wr_ptr <= wr_ptr + frame_rx_pkg::addr_t'(1);
            end
            if (abort) begin
                state <= frame_rx_pkg::st_idle;
            end else begin
                case (state)
                    frame_rx_pkg::st_idle: begin
                        if (sof_byte) begin
                            state <= frame_rx_pkg::st_cmd;
                        end
                    end
                    frame_rx_pkg::st_cmd: begin
                        if (cmd_byte) begin
                            state <= frame_rx_pkg::st_len;
                        end
                    end
                    frame_rx_pkg::st_len: begin
                        // Oversize length drops the frame
                        if (len_byte) begin
                            state <= len_bad ? frame_rx_pkg::st_idle
                                             : frame_rx_pkg::st_payload;
                        end
                    end
                    frame_rx_pkg::st_payload: begin
                        // Done already high for a zero-length frame
                        if (crc_byte) begin
                            state <= frame_rx_pkg::st_idle;
                        end else if (cnt.done) begin
                            state <= frame_rx_pkg::st_crc;
                        end
                    end
                    frame_rx_pkg::st_crc: begin
                        if (crc_byte) begin
                            state <= frame_rx_pkg::st_idle;
                        end
                    end
                    default: begin
                        state <= frame_rx_pkg::st_idle;
                    end
                endcase
            end
        end
    end

    // Header fields, published with each result pulse
    always_ff @(posedge clk) begin
        if (cmd_byte) begin
            cmd_q <= byte_data;
        end
        if (len_byte) begin
            len_q <= frame_rx_pkg::len_t'(byte_data);
        end
        if (pulse_now) begin
            frame_cmd <= cmd_q;
            // Length error reports the low bits of the byte just seen
            frame_len <= len_byte ? frame_rx_pkg::len_t'(byte_data) : len_q;
        end
    end

endmodule

//--- hdl/frame_rx_if.sv
`timescale 1ns/1ps

// Parser to CRC register
interface crc_if;
    // Fold data into the running CRC
    logic update;
    // Back to the seed value, wins over update
    logic clear;
    // Byte to fold in
    frame_rx_pkg::byte_t data;
    // Current CRC register value
    frame_rx_pkg::crc_t crc;

    modport fsm (
        output update,
        output clear,
        output data,
        input  crc
    );

    modport calc (
        input  update,
        input  clear,
        input  data,
        output crc
    );
endinterface

// Parser to payload counter and idle timer
interface count_if;
    // Load remaining count from len
    logic load;
    frame_rx_pkg::len_t len;
    // One payload byte consumed
    logic step;
    // Inside a frame, timer may run
    logic run;
    // Remaining count is zero
    logic done;
    // Too many idle cycles since last load or step
    logic timeout;

    modport fsm (
        output load,
        output len,
        output step,
        output run,
        input  done,
        input  timeout
    );

    modport cnt (
        input  load,
        input  len,
        input  step,
        input  run,
        output done,
        output timeout
    );
endinterface

//--- hdl/frame_rx_pkg.sv
package frame_rx_pkg;

    // One byte of the UART stream
    typedef logic [7:0] byte_t;

    // Running or received CRC8 value
    typedef logic [7:0] crc_t;

    // Payload length or remaining count, 0 to 16
    typedef logic [4:0] len_t;

    // Index into the payload buffer
    typedef logic [3:0] addr_t;

    // Inter-byte idle timer, wide enough to reach the timeout
    typedef logic [6:0] tmr_t;

    // Result code reported with frame_err
    typedef enum logic [1:0] {
        err_none,
        err_crc,
        err_len,
        err_timeout
    } err_code_t;

    // Frame parser states
    typedef enum logic [2:0] {
        st_idle,
        st_cmd,
        st_len,
        st_payload,
        st_crc
    } parser_state_t;

endpackage

//--- hdl/frame_rx_settings.svh
`ifndef FRAME_RX_SETTINGS_SVH
`define FRAME_RX_SETTINGS_SVH

// Frame layout constants

// Start-of-frame marker byte
`define FRAME_SOF 8'hA5

// Largest legal value of the length byte
`define FRAME_MAX_PAYLOAD 16

// Idle cycles inside a frame before it is dropped
`define FRAME_BYTE_TIMEOUT 64

// CRC8 parameters
// x^8 + x^2 + x + 1, MSB first
`define CRC8_POLY 8'h07

// Seed value at start of every frame
`define CRC8_INIT 8'h00

`endif

//--- hdl/payload_buffer.sv
`timescale 1ns/1ps
`include "frame_rx_settings.svh"

module payload_buffer (
    input  logic                clk,
    input  logic                wr_en,
    input  frame_rx_pkg::addr_t wr_addr,
    input  frame_rx_pkg::byte_t wr_data,
    input  frame_rx_pkg::addr_t rd_addr,
    output frame_rx_pkg::byte_t rd_data
);

    // One entry per possible payload byte
    frame_rx_pkg::byte_t mem [`FRAME_MAX_PAYLOAD];

    // Write port, filled in order as payload arrives
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Asynchronous read for the bridge side
    // Old frame stays readable until new payload overwrites it
    assign rd_data = mem[rd_addr];

endmodule

//--- hdl/uart_frame_rx.sv
`timescale 1ns/1ps

module uart_frame_rx (
    input  logic                    clk,
    input  logic                    reset,
    // Byte stream from the UART receiver
    input  logic                    byte_valid,
    input  frame_rx_pkg::byte_t     byte_data,
    // Payload read-back for the bridge
    input  frame_rx_pkg::addr_t     rd_addr,
    output frame_rx_pkg::byte_t     rd_data,
    // Frame result
    output logic                    frame_ok,
    output logic                    frame_err,
    output frame_rx_pkg::err_code_t err_code,
    output frame_rx_pkg::byte_t     frame_cmd,
    output frame_rx_pkg::len_t      frame_len
);

    // Internal buses
    crc_if   crc_bus ();
    count_if cnt_bus ();

    // Buffer write path from the parser
    logic                buf_wr_en;
    frame_rx_pkg::addr_t buf_wr_addr;

    // Running CRC over command, length and payload
    crc8_calc u_crc (
        .clk   (clk),
        .reset (reset),
        .crc   (crc_bus.calc)
    );

    // Payload count and inter-byte timer
    frame_counter u_counter (
        .clk   (clk),
        .reset (reset),
        .cnt   (cnt_bus.cnt)
    );

    // Payload storage, data taken straight off the stream
    payload_buffer u_buffer (
        .clk     (clk),
        .wr_en   (buf_wr_en),
        .wr_addr (buf_wr_addr),
        .wr_data (byte_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Frame state machine
    frame_parser_fsm u_parser (
        .clk         (clk),
        .reset       (reset),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .crc         (crc_bus.fsm),
        .cnt         (cnt_bus.fsm),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .frame_ok    (frame_ok),
        .frame_err   (frame_err),
        .err_code    (err_code),
        .frame_cmd   (frame_cmd),
        .frame_len   (frame_len)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the frame checker and its testbench with Verilator, then run it
# Exit status is nonzero when the build fails or the run ends in $fatal
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert \
    --top-module uart_frame_rx_tb \
    -f uart_frame_rx.f \
    -o uart_frame_rx_sim \
    && ./obj_dir/uart_frame_rx_sim \
    || { echo "simulation failed"; exit 1; }

//--- uart_frame_rx.f
+incdir+hdl
hdl/frame_rx_pkg.sv
hdl/frame_rx_if.sv
hdl/crc8_calc.sv
hdl/frame_counter.sv
hdl/payload_buffer.sv
hdl/frame_parser_fsm.sv
hdl/uart_frame_rx.sv
verif/tb_clock_gen.sv
verif/uart_frame_rx_assert.sv
verif/uart_frame_rx_tb.sv

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held over the first two rising edges
    // Released just after the edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

//--- verif/uart_frame_rx_assert.sv
`timescale 1ns/1ps
`include "frame_rx_settings.svh"

module uart_frame_rx_assert (
    input logic               clk,
    input logic               reset,
    input logic               crc_update,
    input logic               crc_clear,
    input frame_rx_pkg::crc_t crc_value,
    input logic               cnt_step,
    input logic               cnt_done,
    input logic               frame_ok
);

    // Seed value one cycle after reset or clear
    crc_seeded: assert property (@(posedge clk)
        (reset || crc_clear) |=> (crc_value == `CRC8_INIT))
        else $error("CRC register not at its seed after reset or clear");

    // No strobe, no change
    crc_held: assert property (@(posedge clk) disable iff (reset)
        (!crc_update && !crc_clear) |=> $stable(crc_value))
        else $error("CRC register changed without update or clear");

    // Parser never steps an exhausted counter
    step_when_done: assert property (@(posedge clk) disable iff (reset)
        !(cnt_step && cnt_done))
        else $error("Counter stepped while already done");

    // Good-frame strobe is a single cycle
    ok_one_cycle: assert property (@(posedge clk) disable iff (reset)
        frame_ok |=> !frame_ok)
        else $error("frame_ok held for two cycles");

endmodule

// One instance sees the CRC bus, the counter bus and the result pulse
bind uart_frame_rx uart_frame_rx_assert u_assert (
    .clk        (clk),
    .reset      (reset),
    .crc_update (crc_bus.update),
    .crc_clear  (crc_bus.clear),
    .crc_value  (crc_bus.crc),
    .cnt_step   (cnt_bus.step),
    .cnt_done   (cnt_bus.done),
    .frame_ok   (frame_ok)
);

//--- verif/uart_frame_rx_tb.sv
`timescale 1ns/1ps
`include "frame_rx_settings.svh"

module uart_frame_rx_tb;

    localparam int NUM_FRAMES = 200;
    // About 120 cycles per frame covers gaps, stalls and read-back
    localparam int CYCLE_LIMIT = NUM_FRAMES * 120;

    // One captured result pulse
    typedef struct packed {
        logic                    ok;
        logic                    err;
        frame_rx_pkg::err_code_t code;
        frame_rx_pkg::byte_t     cmd;
        frame_rx_pkg::len_t      len;
    } result_t;

    logic                    clk;
    logic                    reset;
    logic                    byte_valid;
    frame_rx_pkg::byte_t     byte_data;
    frame_rx_pkg::addr_t     rd_addr;
    frame_rx_pkg::byte_t     rd_data;
    logic                    frame_ok;
    logic                    frame_err;
    frame_rx_pkg::err_code_t err_code;
    frame_rx_pkg::byte_t     frame_cmd;
    frame_rx_pkg::len_t      frame_len;

    int unsigned rng_state = 59;
    int          cycle_count = 0;
    // Pulses seen by the monitor, not yet checked
    result_t     results[$];

    tb_clock_gen clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    uart_frame_rx UUT (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .frame_ok   (frame_ok),
        .frame_err  (frame_err),
        .err_code   (err_code),
        .frame_cmd  (frame_cmd),
        .frame_len  (frame_len)
    );

    // LCG, upper bits returned
    function automatic int unsigned next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 16;
    endfunction

    // Bit-serial CRC8, MSB first, feedback from top bit
    function automatic frame_rx_pkg::crc_t crc8_model(input frame_rx_pkg::crc_t crc_in,
                                                      input frame_rx_pkg::byte_t data);
        frame_rx_pkg::crc_t c;
        logic feedback;
        c = crc_in;
        for (int i = 7; i >= 0; i--) begin
            feedback = c[7] ^ data[i];
            c = {c[6:0], 1'b0};
            if (feedback) begin
                c = c ^ `CRC8_POLY;
            end
        end
        return c;
    endfunction

    // Keeps filler bytes from opening a frame
    function automatic frame_rx_pkg::byte_t not_sof(input frame_rx_pkg::byte_t value);
        return (value == `FRAME_SOF) ? 8'h00 : value;
    endfunction

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    // Leaves the caller 1 ns after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Gap of 0 to 3 cycles, then a one-cycle strobe
    task automatic send_byte(input frame_rx_pkg::byte_t value);
        idle_cycles(int'(next_random() % 4));
        byte_valid = 1'b1;
        byte_data  = value;
        idle_cycles(1);
        byte_valid = 1'b0;
    endtask

    // Exactly one pulse expected per frame
    task automatic wait_result(output result_t res);
        int waited;
        waited = 0;
        while (results.size() == 0 && waited < 16) begin
            idle_cycles(1);
            waited++;
        end
        assert (results.size() == 1) else begin
            $display("Fail at %0t ns: expected one result pulse, saw %0d", $time, results.size());
            stop_with_failure();
        end
        res = results.pop_front();
    endtask

    task automatic run_frame();
        int                      len;
        int                      total;
        int                      stall_kind;
        int                      stall_at;
        logic                    corrupt;
        frame_rx_pkg::byte_t     body [0:20];
        frame_rx_pkg::crc_t      crc;
        frame_rx_pkg::err_code_t want;
        result_t                 res;
        // Junk the idle parser must skip
        repeat (int'(next_random() % 4)) begin
            send_byte(not_sof(frame_rx_pkg::byte_t'(next_random())));
        end
        // Body is cmd, len, payload, crc; 17 and 18 are oversize
        len = int'(next_random() % 19);
        total = len + 3;
        body[0] = frame_rx_pkg::byte_t'(next_random());
        body[1] = frame_rx_pkg::byte_t'(len);
        for (int i = 0; i < len; i++) begin
            body[i + 2] = frame_rx_pkg::byte_t'(next_random());
        end
        crc = `CRC8_INIT;
        for (int i = 0; i < total - 1; i++) begin
            crc = crc8_model(crc, body[i]);
        end
        // Single bit flip always breaks the match
        corrupt = (next_random() % 6) == 0;
        body[total - 1] = corrupt ? (crc ^ (8'h01 << (next_random() % 8))) : crc;
        // 0 long stall, 1 short stall, else none
        stall_kind = int'(next_random() % 8);
        stall_at = int'(next_random() % total);
        if (len > `FRAME_MAX_PAYLOAD) begin
            stall_kind = 2;
            // Rest is ignored after the length error
            for (int i = 2; i < total; i++) begin
                body[i] = not_sof(body[i]);
            end
        end
        if (len > `FRAME_MAX_PAYLOAD) begin
            want = frame_rx_pkg::err_len;
        end else if (stall_kind == 0) begin
            want = frame_rx_pkg::err_timeout;
        end else if (corrupt) begin
            want = frame_rx_pkg::err_crc;
        end else begin
            want = frame_rx_pkg::err_none;
        end
        send_byte(`FRAME_SOF);
        for (int i = 0; i < total; i++) begin
            if (i == stall_at && stall_kind == 0) begin
                // Well past the limit, frame abandoned
                idle_cycles(`FRAME_BYTE_TIMEOUT + 8 + int'(next_random() % 8));
                break;
            end
            if (i == stall_at && stall_kind == 1) begin
                // Under the limit even before the length byte
                idle_cycles(30 + int'(next_random() % 21));
            end
            send_byte(body[i]);
        end
        wait_result(res);
        if (want == frame_rx_pkg::err_none) begin
            check_value("frame_ok", 1, int'(res.ok));
        end else begin
            check_value("frame_err", 1, int'(res.err));
        end
        check_value("err_code", int'(want), int'(res.code));
        // Header fields may be stale on a timeout
        if (want != frame_rx_pkg::err_timeout) begin
            check_value("frame_cmd", int'(body[0]), int'(res.cmd));
            check_value("frame_len", len, int'(res.len));
        end
        // Payload read-back after a good frame
        if (want == frame_rx_pkg::err_none) begin
            for (int i = 0; i < len; i++) begin
                rd_addr = frame_rx_pkg::addr_t'(i);
                #5;
                check_value("rd_data", int'(body[i + 2]), int'(rd_data));
                idle_cycles(1);
            end
        end
    endtask

    // Result capture mid-cycle, away from the edge
    always @(negedge clk) begin
        if (!reset && (frame_ok || frame_err)) begin
            assert (!(frame_ok && frame_err)) else begin
                $display("Fail at %0t ns: frame_ok and frame_err high together", $time);
                stop_with_failure();
            end
            results.push_back(result_t'({frame_ok, frame_err, err_code, frame_cmd, frame_len}));
        end
    end

    // Run length limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_with_failure();
        end
    end

    initial begin
        byte_valid = 1'b0;
        byte_data  = '0;
        rd_addr    = '0;
        @(negedge reset);
        // Outputs quiet before any frame
        idle_cycles(4);
        check_value("result pulse count", 0, results.size());
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame();
        end
        idle_cycles(8);
        if (results.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("Unexpected result pulse after the last frame");
            stop_with_failure();
        end
    end

endmodule
